// File: verilog/conv_pkg.sv
// image and kernel dimensions, data widths, stream and memory-write structs

package conv_pkg;

    //////////////////////////////////////////////////
    // frame and kernel geometry
    //////////////////////////////////////////////////

    localparam int IMG_W    = 8;
    localparam int IMG_H    = 8;
    localparam int KER_W    = 3;
    localparam int KER_H    = 3;
    localparam int KER_TAPS = KER_W * KER_H;
    localparam int PAD      = KER_W / 2;       // zero border on each side
    localparam int NUM_PIX  = IMG_W * IMG_H;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int PIX_BW  = 8;
    localparam int WGT_BW  = 8;
    localparam int ACC_BW  = PIX_BW * 2 + KER_TAPS;
    localparam int ADDR_BW = $clog2(NUM_PIX);

    // sequencer counters
    localparam int ROW_BW  = $clog2(IMG_H);
    localparam int COL_BW  = $clog2(IMG_W);
    localparam int KROW_BW = $clog2(KER_H);
    localparam int KCOL_BW = $clog2(KER_W);
    localparam int TAP_BW  = $clog2(KER_TAPS);
    localparam int POS_BW  = ROW_BW + 2;       // signed source row/col, room for -PAD

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////

    typedef logic        [PIX_BW-1:0]  pix_t;
    typedef logic signed [WGT_BW-1:0]  wgt_t;
    typedef logic signed [ACC_BW-1:0]  acc_t;
    typedef logic        [ADDR_BW-1:0] addr_t;

    typedef wgt_t [KER_TAPS-1:0] kernel_t;     // tap 0 = top left, row-major

    typedef struct packed {
        logic valid;
        logic last;
        pix_t data;
    } pix_stream_t;

    typedef struct packed {
        logic valid;
        logic last;
        wgt_t data;
    } wgt_stream_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        pix_t  data;
    } ram_wr_t;

    typedef struct packed {
        logic valid;
        logic last;
        acc_t data;
    } out_stream_t;

endpackage

// File: verilog/conv_loader.sv
// input loader: kernel weight capture, pixel-to-memory writes, start pulse

module conv_loader import conv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  pix_stream_t i_pix,
    input  wgt_stream_t i_wgt,
    input  logic        i_busy,
    output ram_wr_t     o_wr,
    output kernel_t     o_kernel,
    output logic        o_start
);

    logic              wgt_take;
    logic              pix_take;
    logic [TAP_BW-1:0] wgt_cnt;
    addr_t             pix_cnt;
    kernel_t           kernel_q;

    logic  wr_en;
    logic  wr_last;
    addr_t wr_addr;
    pix_t  wr_data;
    logic  start_q;

    // nothing is taken while a frame is being computed
    assign wgt_take = i_wgt.valid && !i_busy;
    assign pix_take = i_pix.valid && !i_busy;

    //////////////////////////////////////////////////
    // kernel weights
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wgt_cnt  <= '0;
            kernel_q <= '0;
        end
        else if (wgt_take)
        begin
            if (wgt_cnt < KER_TAPS)
                kernel_q[wgt_cnt] <= i_wgt.data;
            if (i_wgt.last)
                wgt_cnt <= '0;
            else
                wgt_cnt <= wgt_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // pixel stream to frame memory
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            pix_cnt <= '0;
            wr_en   <= 1'b0;
            wr_last <= 1'b0;
            start_q <= 1'b0;
        end
        else
        begin
            wr_en   <= pix_take;
            wr_last <= pix_take && i_pix.last;
            start_q <= wr_last;            // one cycle behind the final write
            if (pix_take)
            begin
                if (i_pix.last)
                    pix_cnt <= '0;
                else
                    pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // write payload
    always_ff @(posedge i_clk)
    begin
        wr_addr <= pix_cnt;
        wr_data <= i_pix.data;
    end

    assign o_wr     = '{we: wr_en, addr: wr_addr, data: wr_data};
    assign o_kernel = kernel_q;
    assign o_start  = start_q;

endmodule

// File: verilog/frame_ram.sv
// frame memory: one write port, one registered read port, single clock

module frame_ram import conv_pkg::*;
(
    input  logic    i_clk,
    input  ram_wr_t i_wr,
    input  addr_t   i_rd_addr,
    output pix_t    o_rd_data
);

    pix_t mem [NUM_PIX];
    pix_t rd_q;

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_wr.we)
            mem[i_wr.addr] <= i_wr.data;
    end

    //////////////////////////////////////////////////
    // read port, data one cycle after address
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        rd_q <= mem[i_rd_addr];
    end

    assign o_rd_data = rd_q;

endmodule

// File: verilog/conv_engine.sv
// convolution engine: window sequencer, padding mask, multiply-accumulate pipeline

module conv_engine import conv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_start,
    input  kernel_t     i_kernel,
    output addr_t       o_rd_addr,
    input  pix_t        i_rd_data,
    output out_stream_t o_out,
    output logic        o_busy
);

    // per-tap tag that rides along the pipeline
    typedef struct packed {
        logic              valid;
        logic              pad;
        logic              first;     // first tap of a window
        logic              ninth;     // final tap of a window
        logic              last_win;
        logic [TAP_BW-1:0] tap;
    } tap_tag_t;

    logic busy;
    logic issuing;

    logic [ROW_BW-1:0]  out_row;
    logic [COL_BW-1:0]  out_col;
    logic [KROW_BW-1:0] tap_row;
    logic [KCOL_BW-1:0] tap_col;

    logic signed [POS_BW-1:0] src_row;
    logic signed [POS_BW-1:0] src_col;
    logic                     src_pad;

    tap_tag_t tag0;
    tap_tag_t tag1;
    tap_tag_t tag2;
    tap_tag_t tag3;

    pix_t                           pix_m;
    logic signed [PIX_BW:0]         pix_op;
    wgt_t                           tap_wgt;
    logic signed [PIX_BW+WGT_BW:0]  prod;
    acc_t                           acc;

    logic out_valid;
    logic out_last;
    acc_t out_data;

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            out_row <= '0;
            out_col <= '0;
            tap_row <= '0;
            tap_col <= '0;
        end
        else if (!busy)
        begin
            if (i_start)
            begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                out_row <= '0;
                out_col <= '0;
                tap_row <= '0;
                tap_col <= '0;
            end
        end
        else
        begin
            if (out_valid && out_last)
                busy <= 1'b0;                  // drained
            if (issuing)
            begin
                if (tap_col == KER_W - 1)
                begin
                    tap_col <= '0;
                    if (tap_row == KER_H - 1)
                    begin
                        tap_row <= '0;
                        if (out_col == IMG_W - 1)
                        begin
                            out_col <= '0;
                            if (out_row == IMG_H - 1)
                                issuing <= 1'b0;
                            else
                                out_row <= out_row + 1'b1;
                        end
                        else
                            out_col <= out_col + 1'b1;
                    end
                    else
                        tap_row <= tap_row + 1'b1;
                end
                else
                    tap_col <= tap_col + 1'b1;
            end
        end
    end

    // source pixel of the current tap
    assign src_row = POS_BW'(out_row) + POS_BW'(tap_row) - POS_BW'(PAD);
    assign src_col = POS_BW'(out_col) + POS_BW'(tap_col) - POS_BW'(PAD);
    assign src_pad = (src_row < 0) || (src_row >= IMG_H) || (src_col < 0) || (src_col >= IMG_W);

    assign o_rd_addr = src_pad ? '0 : addr_t'(int'(src_row) * IMG_W + int'(src_col));

    assign tag0 = '{
        valid:    issuing,
        pad:      src_pad,
        first:    (tap_row == 0) && (tap_col == 0),
        ninth:    (tap_row == KER_H - 1) && (tap_col == KER_W - 1),
        last_win: (out_row == IMG_H - 1) && (out_col == IMG_W - 1),
        tap:      TAP_BW'(tap_row * KER_W + tap_col)
    };

    //////////////////////////////////////////////////
    // read, multiply, accumulate
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            tag1 <= '0;
            tag2 <= '0;
            tag3 <= '0;
        end
        else
        begin
            tag1 <= tag0;
            tag2 <= tag1;
            tag3 <= tag2;
        end
    end

    assign pix_m   = tag1.pad ? '0 : i_rd_data;   // padding taps read as zero
    assign pix_op  = {1'b0, pix_m};
    assign tap_wgt = i_kernel[tag1.tap];

    always_ff @(posedge i_clk)
    begin
        prod <= pix_op * tap_wgt;
        if (tag2.valid)
        begin
            if (tag2.first)
                acc <= acc_t'(prod);
            else
                acc <= acc + acc_t'(prod);
        end
    end

    //////////////////////////////////////////////////
    // result stream
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
        else
        begin
            out_valid <= tag3.valid && tag3.ninth;
            out_last  <= tag3.valid && tag3.ninth && tag3.last_win;
        end
    end

    always_ff @(posedge i_clk)
    begin
        out_data <= acc;
    end

    assign o_out  = '{valid: out_valid, last: out_last, data: out_data};
    assign o_busy = busy;

endmodule

// File: verilog/conv2d_top.sv
// top level: input loader, frame memory and convolution engine

module conv2d_top import conv_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  pix_stream_t i_pix,
    input  wgt_stream_t i_wgt,
    output out_stream_t o_out,
    output logic        o_busy
);

    ram_wr_t ram_wr;
    kernel_t kernel;
    logic    start;
    addr_t   rd_addr;
    pix_t    rd_data;

    //////////////////////////////////////////////////
    // producer
    //////////////////////////////////////////////////

    conv_loader u_loader
    (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_pix    (i_pix),
        .i_wgt    (i_wgt),
        .i_busy   (o_busy),
        .o_wr     (ram_wr),
        .o_kernel (kernel),
        .o_start  (start)
    );

    //////////////////////////////////////////////////
    // frame buffer
    //////////////////////////////////////////////////

    frame_ram u_ram
    (
        .i_clk     (i_clk),
        .i_wr      (ram_wr),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    //////////////////////////////////////////////////
    // consumer
    //////////////////////////////////////////////////

    conv_engine u_engine
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (start),
        .i_kernel  (kernel),
        .o_rd_addr (rd_addr),
        .i_rd_data (rd_data),
        .o_out     (o_out),
        .o_busy    (o_busy)
    );

endmodule

// File: sim/tb_conv_model.svh
// testbench model: kernel and image pattern generators, zero-padded reference convolution

`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

function automatic void make_kernel(input ker_sel_t sel);
    for (int t = 0; t < KER_TAPS; t++)
    begin
        case (sel)
            KER_IDENT: ker[t] = (t == KER_TAPS / 2) ? wgt_t'(1) : wgt_t'(0);
            KER_ONES:  ker[t] = wgt_t'(1);
            default:   ker[t] = wgt_t'($random(seed));
        endcase
    end
    if (sel == KER_RAND && ker[0] >= 0)
        ker[0] = -ker[0] - wgt_t'(1);   // force one negative weight
endfunction

function automatic void make_image(input img_sel_t sel);
    for (int p = 0; p < NUM_PIX; p++)
    begin
        case (sel)
            IMG_RAMP: img[p] = pix_t'(p * 4 + 3);
            IMG_FLAT: img[p] = pix_t'(10);
            default:  img[p] = pix_t'($random(seed));
        endcase
    end
endfunction

// taps that fall outside the frame add nothing to the sum
function automatic void conv_reference();
    int sum;
    int sr;
    int sc;
    for (int r = 0; r < IMG_H; r++)
    begin
        for (int c = 0; c < IMG_W; c++)
        begin
            sum = 0;
            for (int kr = 0; kr < KER_H; kr++)
            begin
                for (int kc = 0; kc < KER_W; kc++)
                begin
                    sr = r + kr - PAD;
                    sc = c + kc - PAD;
                    if (sr >= 0 && sr < IMG_H && sc >= 0 && sc < IMG_W)
                        sum += int'(img[sr * IMG_W + sc]) * int'(ker[kr * KER_W + kc]);
                end
            end
            exp_out[r * IMG_W + c] = acc_t'(sum);
        end
    end
endfunction

`endif

// File: sim/tb_conv2d.sv
// testbench top: clock, reset, stimulus table, frame loop, checker task and report

module tb_conv2d import conv_pkg::*; ();

    localparam int CLK_HALF   = 4;
    localparam int DRIVE_DLY  = 1;
    localparam int RST_CYCLES = 5;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_TESTS  = 5;

    typedef enum int {KER_IDENT, KER_ONES, KER_RAND} ker_sel_t;
    typedef enum int {IMG_RAMP, IMG_FLAT, IMG_RAND} img_sel_t;
    typedef enum int {RUN_PLAIN, RUN_INJECT, RUN_RESET} run_mode_t;

    typedef struct {
        string     name;
        ker_sel_t  ker;
        img_sel_t  img;
        run_mode_t mode;
    } test_row_t;

    logic        i_clk;
    logic        i_rst;
    pix_stream_t i_pix;
    wgt_stream_t i_wgt;
    out_stream_t o_out;
    logic        o_busy;

    int        seed;
    int        err_count;
    int        check_count;
    int        pass_count;
    wgt_t      ker [KER_TAPS];
    pix_t      img [NUM_PIX];
    acc_t      exp_out [NUM_PIX];
    test_row_t tests [NUM_TESTS];

    `include "tb_conv_model.svh"

    conv2d_top dut
    (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_pix  (i_pix),
        .i_wgt  (i_wgt),
        .o_out  (o_out),
        .o_busy (o_busy)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_HALF) i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic step();
        @(posedge i_clk);
        #(DRIVE_DLY);     // just past the edge where outputs have settled
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        check_count++;
        if (expected != actual)
        begin
            err_count++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        i_rst = 1'b1;
        repeat (RST_CYCLES) step();
        i_rst = 1'b0;
    endtask

    task automatic send_frame();
        for (int t = 0; t < KER_TAPS; t++)
        begin
            step();
            i_wgt = '{valid: 1'b1, last: (t == KER_TAPS - 1), data: ker[t]};
        end
        for (int p = 0; p < NUM_PIX; p++)
        begin
            step();
            i_wgt = '0;
            i_pix = '{valid: 1'b1, last: (p == NUM_PIX - 1), data: img[p]};
        end
        step();
        i_pix = '0;
    endtask

    task automatic wait_busy(input string name, input logic level);
        int n = 0;
        while (o_busy !== level && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (o_busy !== level)
        begin
            err_count++;
            $display("%s: busy never went to %0d", name, level);
        end
    endtask

    // no stray result beats and no busy while the DUT should sit idle
    task automatic check_idle(input string name, input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            check_value({name, " idle valid"}, 0, longint'(o_out.valid));
            check_value({name, " idle busy"}, 0, longint'(o_busy));
            step();
        end
    endtask

    task automatic collect_frame(input string name, input logic inject);
        int   beats = 0;
        int   idle = 0;
        int   inj = 0;
        logic done = 1'b0;
        while (!done && idle < WAIT_LIMIT)
        begin
            step();
            i_wgt = '0;
            i_pix = '0;
            if (o_out.valid)
            begin
                if (beats < NUM_PIX)
                    check_value({name, " sum"}, longint'(exp_out[beats]), longint'(o_out.data));
                check_value({name, " last"}, longint'(beats == NUM_PIX - 1), longint'(o_out.last));
                done = o_out.last;
                beats++;
                idle = 0;
            end
            else
                idle++;
            // junk kernel and pixels while the frame runs
            if (inject && o_busy && inj < NUM_PIX)
            begin
                i_wgt = '{valid: (inj < KER_TAPS), last: (inj == KER_TAPS - 1), data: wgt_t'(-5)};
                i_pix = '{valid: 1'b1, last: (inj == NUM_PIX - 1), data: pix_t'(inj)};
                inj++;
            end
        end
        i_wgt = '0;
        i_pix = '0;
        if (!done)
        begin
            err_count++;
            $display("%s: no last result beat arrived", name);
        end
        check_value({name, " beats"}, longint'(NUM_PIX), longint'(beats));
        wait_busy(name, 1'b0);
        check_idle(name, 2 * KER_TAPS);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial
    begin
        int errs_before;
        seed        = 64600;
        err_count   = 0;
        check_count = 0;
        pass_count  = 0;
        i_rst       = 1'b1;
        i_pix       = '0;
        i_wgt       = '0;
        tests[0] = '{"identity_ramp", KER_IDENT, IMG_RAMP, RUN_PLAIN};
        tests[1] = '{"ones_flat", KER_ONES, IMG_FLAT, RUN_PLAIN};
        tests[2] = '{"random_signed", KER_RAND, IMG_RAND, RUN_PLAIN};
        tests[3] = '{"busy_ignore", KER_RAND, IMG_RAND, RUN_INJECT};
        tests[4] = '{"reset_fresh", KER_RAND, IMG_RAMP, RUN_RESET};
        apply_reset();
        foreach (tests[i])
        begin
            errs_before = err_count;
            make_kernel(tests[i].ker);
            make_image(tests[i].img);
            conv_reference();
            if (tests[i].mode == RUN_RESET)
            begin
                send_frame();
                wait_busy(tests[i].name, 1'b1);
                apply_reset();    // cut the frame short
                check_idle({tests[i].name, " after reset"}, 2 * KER_TAPS);
            end
            send_frame();
            collect_frame(tests[i].name, tests[i].mode == RUN_INJECT);
            if (err_count == errs_before)
            begin
                pass_count++;
                $display("test %s: pass", tests[i].name);
            end
            else
                $display("test %s: FAIL, %0d errors", tests[i].name, err_count - errs_before);
        end
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS,
                 pass_count, NUM_TESTS - pass_count, check_count, err_count);
        if (err_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+sim
verilog/conv_pkg.sv
verilog/conv_loader.sv
verilog/frame_ram.sv
verilog/conv_engine.sv
verilog/conv2d_top.sv
sim/tb_conv2d.sv

// File: run_sim.sh
#!/bin/sh
# build the conv2d testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tb_conv2d -o sim_conv2d \
    && ./obj_dir/sim_conv2d | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
